/* bench/lcd_bus_monitor.sv */
`default_nettype none

module lcd_bus_monitor (
	input  logic       clk,
	input  logic       rst,
	input  logic       e,
	input  logic       rs,
	input  logic [7:0] lcd_data,
	output logic       word_valid,  // one cycle after each falling edge of e
	output logic [8:0] word,        // {rs, data} seen while e was high
	output int         high_len,
	output int         rise_gap,    // cycles between the last two rising edges
	output logic       stable,
	output int         word_count
);

	logic       e_q;
	logic [8:0] held;
	logic       stable_q;
	int         hi_cnt;
	int         since_rise;

	always_ff @(posedge clk) begin
		if (rst) begin
			e_q        <= 1'b0;
			word_valid <= 1'b0;
			word_count <= 0;
			hi_cnt     <= 0;
			since_rise <= 0;
			rise_gap   <= 0;
			stable_q   <= 1'b1;
		end else begin
			word_valid <= 1'b0;
			since_rise <= since_rise + 1;
			if (e && !e_q) begin
				hi_cnt     <= 1;
				held       <= {rs, lcd_data};
				stable_q   <= 1'b1;
				rise_gap   <= since_rise;
				since_rise <= 1;
			end else if (e) begin
				hi_cnt <= hi_cnt + 1;
				if ({rs, lcd_data} != held)
					stable_q <= 1'b0;   // bus moved under e
			end else if (e_q) begin
				word_valid <= 1'b1;
				word       <= held;
				high_len   <= hi_cnt;
				stable     <= stable_q;
				word_count <= word_count + 1;
			end
			e_q <= e;
		end
	end

endmodule

`default_nettype wire

/* bench/tb_lcd_top.sv */
`default_nettype none

module tb_lcd_top;
	import lcd_pkg::*;

	localparam int E_HIGH_CYC  = T_E_HIGH_US * CLK_PER_US;
	localparam int INIT_LIMIT  = 5000;
	localparam int READY_LIMIT = 2000;
	localparam int DRAIN_LIMIT = 20000;

	logic        clk;
	logic        rst;
	logic [6:0]  lcd_config;
	logic        char_valid;
	logic [7:0]  char_code;
	logic        char_row;
	logic [3:0]  char_col;
	logic        char_ready;
	logic        cmd_valid;
	lcd_cmd_op_t cmd_op;
	logic        cmd_ready;
	logic        e;
	logic        rs;
	logic [7:0]  lcd_data;
	logic        busy;

	logic       mon_valid;
	logic [8:0] mon_word;
	int         mon_high;
	int         mon_gap;
	logic       mon_stable;
	int         mon_count;

	logic [8:0] exp_init[$];
	logic [8:0] exp_text[$];
	logic [8:0] exp_cmd[$];
	logic       pending_addr;
	int         cmds_between;
	int         mismatch_cnt;
	int         timing_cnt;
	int         other_cnt;
	logic       timed_out;

	lcd_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.lcd_config (lcd_config),
		.char_valid (char_valid),
		.char_code  (char_code),
		.char_row   (char_row),
		.char_col   (char_col),
		.char_ready (char_ready),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_ready  (cmd_ready),
		.e          (e),
		.rs         (rs),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

	lcd_bus_monitor i_monitor (
		.clk        (clk),
		.rst        (rst),
		.e          (e),
		.rs         (rs),
		.lcd_data   (lcd_data),
		.word_valid (mon_valid),
		.word       (mon_word),
		.high_len   (mon_high),
		.rise_gap   (mon_gap),
		.stable     (mon_stable),
		.word_count (mon_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// pulse timing applies to normal transfers after the four init words
	a_e_high: assert property (@(posedge clk) disable iff (rst)
		(mon_valid && mon_count > 4) |-> mon_high == E_HIGH_CYC)
		else begin
			timing_cnt++;
			$display("Mismatch at %0t: e high for %0d cycles, expected %0d",
				$time, mon_high, E_HIGH_CYC);
		end

	a_rise_gap: assert property (@(posedge clk) disable iff (rst)
		(mon_valid && mon_count > 4) |-> mon_gap >= T_XFER_US * CLK_PER_US)
		else begin
			timing_cnt++;
			$display("Mismatch at %0t: rising edges of e only %0d cycles apart", $time, mon_gap);
		end

	a_bus_stable: assert property (@(posedge clk) disable iff (rst)
		mon_valid |-> mon_stable)
		else begin
			timing_cnt++;
			$display("Mismatch at %0t: rs or data changed while e was high", $time);
		end

	// busy must not drop before the fourth init word
	a_busy_init: assert property (@(posedge clk) disable iff (rst)
		(mon_count < 4 && $past(busy)) |-> busy)
		else begin
			other_cnt++;
			$display("Busy fell at %0t before initialization was complete", $time);
		end

	// an accepted strobe drops the client's ready level
	a_char_unready: assert property (@(posedge clk) disable iff (rst)
		(char_valid && char_ready) |=> !char_ready)
		else begin
			other_cnt++;
			$display("Text writer stayed ready at %0t after taking a character", $time);
		end

	a_cmd_unready: assert property (@(posedge clk) disable iff (rst)
		(cmd_valid && cmd_ready) |=> !cmd_ready)
		else begin
			other_cnt++;
			$display("Command issuer stayed ready at %0t after taking a command", $time);
		end

	function automatic logic [7:0] expected_ins(input lcd_cmd_op_t op);
		case (op)
			CMD_CLEAR:       expected_ins = 8'h01;
			CMD_HOME:        expected_ins = 8'h02;
			CMD_DISPLAY_ON:  expected_ins = 8'h0c;
			CMD_DISPLAY_OFF: expected_ins = 8'h08;
			CMD_SHIFT_LEFT:  expected_ins = 8'h18;
			default:         expected_ins = 8'h1c;
		endcase
	endfunction

	task automatic print_counts();
		$display("Mismatches: %0d, timing errors: %0d, other errors: %0d",
			mismatch_cnt, timing_cnt, other_cnt);
	endtask

	task automatic report_timeout(input string msg);
		$display("Error at %0t: %s", $time, msg);
		other_cnt++;
		timed_out = 1'b1;
	endtask

	task automatic compare_word(input logic [8:0] got, input logic [8:0] exp, input string what);
		assert (got == exp)
			else begin
				mismatch_cnt++;
				$display("Mismatch at %0t: %s word %h, expected %h", $time, what, got, exp);
			end
	endtask

	// route each captured word to its client by rs and bit 7
	task automatic check_word(input logic [8:0] got, input int idx);
		if (idx <= 4) begin
			compare_word(got, exp_init.pop_front(), "init");
		end else if (got[8] || got[7]) begin
			if (exp_text.size() == 0) begin
				mismatch_cnt++;
				$display("Mismatch at %0t: unexpected text word %h", $time, got);
			end else begin
				compare_word(got, exp_text.pop_front(), "text");
			end
			if (!got[8]) begin
				if (pending_addr) begin
					other_cnt++;
					$display("Address word at %0t while a character was still pending", $time);
				end
				pending_addr = 1'b1;
				cmds_between = 0;
			end else begin
				if (!pending_addr) begin
					other_cnt++;
					$display("Character at %0t without its address word", $time);
				end
				pending_addr = 1'b0;
			end
		end else begin
			if (exp_cmd.size() == 0) begin
				mismatch_cnt++;
				$display("Mismatch at %0t: unexpected command word %h", $time, got);
			end else begin
				compare_word(got, exp_cmd.pop_front(), "command");
			end
			if (pending_addr)
				cmds_between++;
			assert (cmds_between <= 1)
				else begin
					other_cnt++;
					$display("More than one command between address and character at %0t", $time);
				end
		end
	endtask

	always @(posedge clk) begin
		if (!rst && mon_valid)
			check_word(mon_word, mon_count);
	end

	task automatic send_char(input logic [7:0] code, input logic row, input logic [3:0] col);
		int t;
		logic [7:0] addr;
		t = 0;
		addr = 8'h80 + (row ? 8'h40 : 8'h00) + {4'b0000, col};
		@(posedge clk);
		while (!char_ready && !timed_out && t < READY_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (t >= READY_LIMIT) begin
			report_timeout("text writer never became ready");
		end else if (!timed_out) begin
			char_valid <= 1'b1;
			char_code  <= code;
			char_row   <= row;
			char_col   <= col;
			exp_text.push_back({1'b0, addr});
			exp_text.push_back({1'b1, code});
			@(posedge clk);
			char_valid <= 1'b0;
		end
	endtask

	task automatic send_cmd(input lcd_cmd_op_t op);
		int t;
		t = 0;
		@(posedge clk);
		while (!cmd_ready && !timed_out && t < READY_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (t >= READY_LIMIT) begin
			report_timeout("command issuer never became ready");
		end else if (!timed_out) begin
			cmd_valid <= 1'b1;
			cmd_op    <= op;
			exp_cmd.push_back({1'b0, expected_ins(op)});
			@(posedge clk);
			cmd_valid <= 1'b0;
		end
	endtask

	task automatic wait_init();
		int t;
		t = 0;
		while ((mon_count < 4 || busy) && t < INIT_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (t >= INIT_LIMIT)
			report_timeout("controller never finished initialization");
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while ((exp_text.size() != 0 || exp_cmd.size() != 0) && !timed_out
			&& t < DRAIN_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (t >= DRAIN_LIMIT)
			report_timeout("expected bus words never arrived");
	endtask

	initial begin
		void'($urandom(39403));
		rst          = 1'b1;
		lcd_config   = 7'($urandom());
		char_valid   = 1'b0;
		char_code    = 8'h00;
		char_row     = 1'b0;
		char_col     = 4'h0;
		cmd_valid    = 1'b0;
		cmd_op       = CMD_CLEAR;
		pending_addr = 1'b0;
		cmds_between = 0;
		mismatch_cnt = 0;
		timing_cnt   = 0;
		other_cnt    = 0;
		timed_out    = 1'b0;
		exp_init.push_back({1'b0, 4'b0011, lcd_config[6:5], 2'b00});
		exp_init.push_back({1'b0, 5'b00001, lcd_config[4:2]});
		exp_init.push_back({1'b0, 8'h01});
		exp_init.push_back({1'b0, 6'b000001, lcd_config[1:0]});
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		wait_init();
		for (int i = 0; i < 6; i++) begin
			send_cmd(lcd_cmd_op_t'(i));
			wait_drained();
		end
		repeat (4) begin
			send_char(8'($urandom()), 1'($urandom()), 4'($urandom()));
			wait_drained();
		end
		// both clients at once and back to back
		repeat (6) begin
			fork
				send_char(8'($urandom()), 1'($urandom()), 4'($urandom()));
				send_cmd(lcd_cmd_op_t'($urandom_range(0, 5)));
			join
		end
		wait_drained();
		if (pending_addr) begin
			other_cnt++;
			$display("Last address word was never followed by its character");
		end
		print_counts();
		if (mismatch_cnt + timing_cnt + other_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/lcd_pkg.sv
hw/lcd_ctrl.sv
hw/lcd_arbiter.sv
hw/lcd_text_writer.sv
hw/lcd_cmd_issuer.sv
hw/lcd_top.sv
bench/lcd_bus_monitor.sv
bench/tb_lcd_top.sv

/* hw/lcd_arbiter.sv */
`default_nettype none

module lcd_arbiter (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           busy,
	input  logic                           req_text,
	input  logic [lcd_pkg::LCD_WORD_W-1:0] word_text,
	input  logic                           req_cmd,
	input  logic [lcd_pkg::LCD_WORD_W-1:0] word_cmd,
	output logic                           grant_text,
	output logic                           grant_cmd,
	output logic                           lcd_enable,
	output logic [lcd_pkg::LCD_WORD_W-1:0] lcd_bus
);
	import lcd_pkg::*;

	logic last_cmd;   // round-robin pointer, cmd client served last
	logic can_issue;
	logic pick_text;
	logic pick_cmd;

	// busy only rises the cycle after the strobe, so the registered strobe
	// itself holds off a second issue
	assign can_issue = !busy && !lcd_enable;

	assign pick_text = can_issue && req_text && (!req_cmd || last_cmd);
	assign pick_cmd  = can_issue && req_cmd && (!req_text || !last_cmd);

	always_ff @(posedge clk) begin
		if (rst) begin
			grant_text <= 1'b0;
			grant_cmd  <= 1'b0;
			lcd_enable <= 1'b0;
			last_cmd   <= 1'b1;   // text wins the first tie
		end else begin
			grant_text <= pick_text;
			grant_cmd  <= pick_cmd;
			lcd_enable <= pick_text || pick_cmd;
			if (pick_text)
				last_cmd <= 1'b0;
			else if (pick_cmd)
				last_cmd <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pick_text)
			lcd_bus <= word_text;
		else if (pick_cmd)
			lcd_bus <= word_cmd;
	end

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		!(grant_text && grant_cmd));

endmodule

`default_nettype wire

/* hw/lcd_cmd_issuer.sv */
`default_nettype none

module lcd_cmd_issuer (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           cmd_valid,
	input  lcd_pkg::lcd_cmd_op_t           cmd_op,
	output logic                           cmd_ready,
	output logic                           req,
	output logic [lcd_pkg::LCD_WORD_W-1:0] word,
	input  logic                           grant
);
	import lcd_pkg::*;

	logic accept;

	function automatic logic [7:0] op_to_ins(input lcd_cmd_op_t op);
		case (op)
			CMD_CLEAR:       op_to_ins = INS_CLEAR;
			CMD_HOME:        op_to_ins = INS_HOME;
			CMD_DISPLAY_ON:  op_to_ins = 8'h0c;   // display on, cursor and blink off
			CMD_DISPLAY_OFF: op_to_ins = 8'h08;
			CMD_SHIFT_LEFT:  op_to_ins = 8'h18;   // display shift, left
			CMD_SHIFT_RIGHT: op_to_ins = 8'h1c;
			default:         op_to_ins = 8'h00;   // no-op on the lcd
		endcase
	endfunction

	assign accept    = cmd_valid && cmd_ready;
	assign cmd_ready = !req;

	always_ff @(posedge clk) begin
		if (rst)
			req <= 1'b0;
		else if (accept)
			req <= 1'b1;
		else if (grant)
			req <= 1'b0;
	end

	// instruction word, rs and rw both low
	always_ff @(posedge clk) begin
		if (accept)
			word <= {2'b00, op_to_ins(cmd_op)};
	end

	a_known_op: assert property (@(posedge clk) disable iff (rst)
		accept |-> cmd_op inside {CMD_CLEAR, CMD_HOME, CMD_DISPLAY_ON, CMD_DISPLAY_OFF,
			CMD_SHIFT_LEFT, CMD_SHIFT_RIGHT});

endmodule

`default_nettype wire

/* hw/lcd_ctrl.sv */
`default_nettype none

module lcd_ctrl (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [6:0]                     lcd_config, // {lines, font, disp, cursor, blink, inc, shift}
	input  logic                           lcd_enable,
	input  logic [lcd_pkg::LCD_WORD_W-1:0] lcd_bus,
	output logic                           e,
	output logic                           rs,
	output logic [7:0]                     lcd_data,
	output logic                           busy
);
	import lcd_pkg::*;

	lcd_ctrl_state_t  state;
	logic [CNT_W-1:0] cnt;      // cycle index within the current phase
	logic [CNT_W-1:0] cnt_inc;
	logic [6:0]       cfg;      // config held for the whole init

	assign cnt_inc = cnt + CNT_W'(1);

	// e level for a given init cycle, one pulse at the start of each step
	function automatic logic init_pulse(input logic [CNT_W-1:0] idx);
		logic p0;
		logic p1;
		logic p2;
		logic p3;
		p0 = idx < CNT_W'(INIT_PULSE_CYC);
		p1 = idx >= CNT_W'(INIT_B1) && idx < CNT_W'(INIT_B1 + INIT_PULSE_CYC);
		p2 = idx >= CNT_W'(INIT_B2) && idx < CNT_W'(INIT_B2 + INIT_PULSE_CYC);
		p3 = idx >= CNT_W'(INIT_B3) && idx < CNT_W'(INIT_B3 + INIT_PULSE_CYC);
		init_pulse = p0 || p1 || p2 || p3;
	endfunction

	// instruction byte shown during a given init cycle
	function automatic logic [7:0] init_word(input logic [CNT_W-1:0] idx, input logic [6:0] c);
		if (idx < CNT_W'(INIT_B1))
			init_word = {4'b0011, c[6], c[5], 2'b00};  // function set, 8 bit bus
		else if (idx < CNT_W'(INIT_B2))
			init_word = {5'b00001, c[4:2]};            // display control
		else if (idx < CNT_W'(INIT_B3))
			init_word = INS_CLEAR;
		else
			init_word = {6'b000001, c[1:0]};           // entry mode
	endfunction

	// e level for a given cycle counted from the strobe
	function automatic logic xfer_pulse(input logic [CNT_W-1:0] idx);
		xfer_pulse = idx >= CNT_W'(E_SETUP_CYC) && idx < CNT_W'(E_END_CYC);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_POWER;
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b0;
		end else begin
			case (state)
				ST_POWER: begin
					busy <= 1'b1;
					if (cnt == CNT_W'(POWER_CYC - 1)) begin
						state    <= ST_INIT;
						cnt      <= '0;
						cfg      <= lcd_config;            // sampled once per init
						e        <= init_pulse('0);
						lcd_data <= init_word('0, lcd_config);
					end else begin
						cnt <= cnt_inc;
					end
				end
				ST_INIT: begin
					if (cnt == CNT_W'(INIT_CYC - 1)) begin
						state    <= ST_IDLE;
						cnt      <= '0;
						e        <= 1'b0;
						lcd_data <= '0;
						busy     <= 1'b0;                  // init done
					end else begin
						cnt      <= cnt_inc;
						e        <= init_pulse(cnt_inc);
						lcd_data <= init_word(cnt_inc, cfg); // held through each wait
					end
				end
				ST_IDLE: begin
					if (lcd_enable) begin
						state    <= ST_XFER;
						cnt      <= CNT_W'(1);             // strobe cycle counts as 0
						e        <= xfer_pulse(CNT_W'(1));
						rs       <= lcd_bus[LCD_WORD_W-1];
						lcd_data <= lcd_bus[7:0];
						busy     <= 1'b1;
					end
				end
				ST_XFER: begin
					if (cnt == CNT_W'(XFER_CYC - 1)) begin
						state    <= ST_IDLE;
						cnt      <= '0;
						e        <= 1'b0;
						rs       <= 1'b0;
						lcd_data <= '0;
						busy     <= 1'b0;
					end else begin
						cnt <= cnt_inc;
						e   <= xfer_pulse(cnt_inc);        // rs and data stay put
					end
				end
				default: state <= ST_POWER;
			endcase
		end
	end

	a_no_e_in_idle: assert property (@(posedge clk) disable iff (rst)
		(state == ST_IDLE) |-> !$rose(e));

	// arbiter must respect the busy level
	a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
		lcd_enable |-> !busy);

	// r/w is tied low on the board, clients only write
	a_write_only: assert property (@(posedge clk) disable iff (rst)
		lcd_enable |-> !lcd_bus[LCD_WORD_W-2]);

endmodule

`default_nettype wire

/* hw/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	localparam int CLK_PER_US = 2;        // board builds raise this

	localparam int T_POWER_US      = 500;
	localparam int T_INIT_PULSE_US = 10;
	localparam int T_WAIT_SHORT_US = 50;  // after function set and display control
	localparam int T_WAIT_CLEAR_US = 200;
	localparam int T_WAIT_ENTRY_US = 100;
	localparam int T_XFER_US       = 50;
	localparam int T_E_SETUP_US    = 1;
	localparam int T_E_HIGH_US     = 13;

	// cycle counts derived from the microsecond figures
	localparam int POWER_CYC      = T_POWER_US * CLK_PER_US;
	localparam int INIT_PULSE_CYC = T_INIT_PULSE_US * CLK_PER_US;
	localparam int INIT_B1        = (T_INIT_PULSE_US + T_WAIT_SHORT_US) * CLK_PER_US;
	localparam int INIT_B2        = INIT_B1 * 2;   // start of clear step
	localparam int INIT_B3        = INIT_B2 + (T_INIT_PULSE_US + T_WAIT_CLEAR_US) * CLK_PER_US;
	localparam int INIT_CYC       = INIT_B3 + (T_INIT_PULSE_US + T_WAIT_ENTRY_US) * CLK_PER_US;
	localparam int XFER_CYC       = T_XFER_US * CLK_PER_US;
	localparam int E_SETUP_CYC    = T_E_SETUP_US * CLK_PER_US;
	localparam int E_END_CYC      = E_SETUP_CYC + T_E_HIGH_US * CLK_PER_US;

	// one counter covers the longest phase
	localparam int CNT_MAX = (POWER_CYC > INIT_CYC) ? POWER_CYC : INIT_CYC;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);

	localparam int LCD_WORD_W = 10;       // {rs, rw, data}

	localparam logic [7:0] INS_CLEAR      = 8'h01;
	localparam logic [7:0] INS_HOME       = 8'h02;
	localparam logic [7:0] INS_DDRAM_BASE = 8'h80;
	localparam logic [6:0] ROW1_OFFSET    = 7'h40;

	typedef enum logic [2:0] {
		CMD_CLEAR,
		CMD_HOME,
		CMD_DISPLAY_ON,
		CMD_DISPLAY_OFF,
		CMD_SHIFT_LEFT,
		CMD_SHIFT_RIGHT
	} lcd_cmd_op_t;

	typedef enum logic [1:0] {
		ST_POWER,
		ST_INIT,
		ST_IDLE,
		ST_XFER
	} lcd_ctrl_state_t;

endpackage

`default_nettype wire

/* hw/lcd_text_writer.sv */
`default_nettype none

module lcd_text_writer (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           char_valid,
	input  logic [7:0]                     char_code,
	input  logic                           char_row,
	input  logic [3:0]                     char_col,
	output logic                           char_ready,
	output logic                           req,
	output logic [lcd_pkg::LCD_WORD_W-1:0] word,
	input  logic                           grant
);
	import lcd_pkg::*;

	logic [7:0] code_q;
	logic       row_q;
	logic [3:0] col_q;
	logic       data_phase;   // address word sent, character next
	logic [6:0] ddram_addr;
	logic       accept;

	assign accept = char_valid && char_ready;

	// row 1 starts at 0x40 in ddram
	assign ddram_addr = (row_q ? ROW1_OFFSET : 7'h00) + {3'b000, col_q};

	assign word = data_phase ? {1'b1, 1'b0, code_q}
		: {2'b00, INS_DDRAM_BASE | {1'b0, ddram_addr}};

	// busy from the strobe until the character word is granted
	assign char_ready = !req;

	always_ff @(posedge clk) begin
		if (rst) begin
			req        <= 1'b0;
			data_phase <= 1'b0;
		end else if (accept) begin
			req        <= 1'b1;
			data_phase <= 1'b0;
		end else if (grant) begin
			if (data_phase) begin
				req        <= 1'b0;   // both words out
				data_phase <= 1'b0;
			end else begin
				data_phase <= 1'b1;   // keep req up, present the character
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			code_q <= char_code;
			row_q  <= char_row;
			col_q  <= char_col;
		end
	end

	// arbiter only grants a raised request
	a_grant_needs_req: assert property (@(posedge clk) disable iff (rst)
		grant |-> req);

endmodule

`default_nettype wire

/* hw/lcd_top.sv */
`default_nettype none

module lcd_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [6:0]           lcd_config,
	input  logic                 char_valid,
	input  logic [7:0]           char_code,
	input  logic                 char_row,
	input  logic [3:0]           char_col,
	output logic                 char_ready,
	input  logic                 cmd_valid,
	input  lcd_pkg::lcd_cmd_op_t cmd_op,
	output logic                 cmd_ready,
	output logic                 e,
	output logic                 rs,
	output logic [7:0]           lcd_data,
	output logic                 busy
);
	import lcd_pkg::*;

	logic                  req_text;
	logic                  grant_text;
	logic [LCD_WORD_W-1:0] word_text;
	logic                  req_cmd;
	logic                  grant_cmd;
	logic [LCD_WORD_W-1:0] word_cmd;
	logic                  lcd_enable;   // one-cycle strobe into the controller
	logic [LCD_WORD_W-1:0] lcd_bus;

	lcd_text_writer i_text (
		.clk        (clk),
		.rst        (rst),
		.char_valid (char_valid),
		.char_code  (char_code),
		.char_row   (char_row),
		.char_col   (char_col),
		.char_ready (char_ready),
		.req        (req_text),
		.word       (word_text),
		.grant      (grant_text)
	);

	lcd_cmd_issuer i_cmd (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_ready (cmd_ready),
		.req       (req_cmd),
		.word      (word_cmd),
		.grant     (grant_cmd)
	);

	lcd_arbiter i_arbiter (
		.clk        (clk),
		.rst        (rst),
		.busy       (busy),
		.req_text   (req_text),
		.word_text  (word_text),
		.req_cmd    (req_cmd),
		.word_cmd   (word_cmd),
		.grant_text (grant_text),
		.grant_cmd  (grant_cmd),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus)
	);

	lcd_ctrl i_ctrl (
		.clk        (clk),
		.rst        (rst),
		.lcd_config (lcd_config),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.rs         (rs),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the LCD subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f flist.f --top-module tb_lcd_top -o sim_lcd
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_lcd)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
	exit 0
fi
exit 1
